// ==== flist.f ====
common/rv_pkg.sv
common/mdu_pkg.sv
div/div.sv
mul/mul.sv
verilog/mdu_dispatch.sv
verilog/wb_arbiter.sv
verilog/mdu_top.sv
sim/mdu_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build the testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f flist.f --top-module mdu_tb -o mdu_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/mdu_sim)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -qx "No errors"; then
    exit 0
fi
echo "simulation reported failures"
exit 1

// ==== sim/mdu_tb.sv ====
`default_nettype none
`timescale 1ns/10ps

module mdu_tb;

    import rv_pkg::*;
    import mdu_pkg::*;

    localparam int xw         = 32;
    localparam int n_mul_rand = 8;
    localparam int n_div_rand = 5;
    localparam int n_ops      = 4 * (36 + n_mul_rand + n_div_rand) + 12 + 6 + 13;
    localparam int wd_cycles  = n_ops * 60 + 1000;
    localparam logic [xw-1:0] min_int = 32'h8000_0000;

    logic          clk;
    logic          rst;
    logic          issue_valid;
    mdu_op_e       issue_op;
    reg_addr_t     issue_rd;
    logic [xw-1:0] issue_a;
    logic [xw-1:0] issue_b;
    logic          issue_ready;
    logic          wb_valid;
    reg_addr_t     wb_rd;
    logic [xw-1:0] wb_data;

    // scoreboard indexed by rd
    logic [xw-1:0] exp_data [32];
    bit            pend     [32];
    bit            pend_div [32];
    int            acc_cyc  [32]; // cycle of the accept edge

    bit            model_div_busy;
    int            cyc = 0;
    int            errors = 0;
    int            err_mark = 0;
    int            n_tests = 0;
    int            n_checked = 0;
    int            next_rd = 0;
    logic [31:0]   seed = 32'd62511;
    logic [xw-1:0] edge_vals [6] = '{32'h0, 32'h1, 32'hffff_ffff, 32'h8000_0000,
                                     32'h7fff_ffff, 32'h0001_ffff};

    mdu_top #(.xlen(xw)) u_dut (
        .clk         (clk),
        .rst         (rst),
        .issue_valid (issue_valid),
        .issue_op    (issue_op),
        .issue_rd    (issue_rd),
        .issue_a     (issue_a),
        .issue_b     (issue_b),
        .issue_ready (issue_ready),
        .wb_valid    (wb_valid),
        .wb_rd       (wb_rd),
        .wb_data     (wb_data)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) cyc <= cyc + 1;

    function automatic logic [31:0] lcg_next();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    // RISC-V M extension results
    function automatic logic [xw-1:0] ref_result(input mdu_op_e op, input logic [xw-1:0] a,
                                                 input logic [xw-1:0] b);
        int            sa;
        int            sb;
        longint        ps_ss;
        longint        ps_su;
        logic [63:0]   pu;
        logic [xw-1:0] q;
        logic [xw-1:0] r;
        logic          ovf;
        sa    = $signed(a);
        sb    = $signed(b);
        ps_ss = longint'(sa) * longint'(sb);
        ps_su = longint'(sa) * longint'({32'b0, b});
        pu    = {32'b0, a} * {32'b0, b};
        ovf   = (a == min_int) && (b == '1);
        q     = '0;
        r     = '0;
        if (b != 0 && !ovf) begin
            q = sa / sb; // truncates toward zero
            r = sa % sb; // takes the dividend's sign
        end
        case (op)
            op_mul:    return pu[31:0];
            op_mulh:   return ps_ss[63:32];
            op_mulhsu: return ps_su[63:32];
            op_mulhu:  return pu[63:32];
            op_div:    return (b == 0) ? '1 : (ovf ? a : q);
            op_divu:   return (b == 0) ? '1 : a / b;
            op_rem:    return (b == 0) ? a : (ovf ? '0 : r);
            default:   return (b == 0) ? a : a % b;
        endcase
    endfunction

    function automatic reg_addr_t free_rd();
        int r;
        for (int k = 0; k < 31; k++) begin
            r = 1 + (next_rd + k) % 31;
            if (!pend[r]) begin
                next_rd = r;
                return reg_addr_t'(r);
            end
        end
        return reg_addr_t'(0);
    endfunction

    function automatic int pend_count();
        int n;
        n = 0;
        for (int r = 0; r < 32; r++) begin
            n += int'(pend[r]);
        end
        return n;
    endfunction

    function automatic bit mul_overdue();
        for (int r = 1; r < 32; r++) begin
            if (pend[r] && !pend_div[r] && cyc - acc_cyc[r] > 2) begin
                return 1'b1;
            end
        end
        return 1'b0;
    endfunction

    a_wb_known: assert property (@(negedge clk) disable iff (rst) wb_valid |-> pend[wb_rd])
        else begin
            $display("write-back to rd %0d with no operation outstanding", wb_rd);
            errors++;
        end

    a_wb_data: assert property (@(negedge clk) disable iff (rst)
        wb_valid |-> wb_data == exp_data[wb_rd])
        else begin
            $display("ERROR wb_data rd %0d: expected %h, got %h", wb_rd, exp_data[wb_rd],
                     wb_data);
            errors++;
        end

    a_mul_latency: assert property (@(negedge clk) disable iff (rst)
        wb_valid && !pend_div[wb_rd] |-> cyc - acc_cyc[wb_rd] == 2)
        else begin
            $display("multiply to rd %0d written back after %0d cycles instead of 2",
                     wb_rd, cyc - acc_cyc[wb_rd]);
            errors++;
        end

    a_div_latency: assert property (@(negedge clk) disable iff (rst)
        wb_valid && pend_div[wb_rd] |-> cyc - acc_cyc[wb_rd] >= 36)
        else begin
            $display("divide to rd %0d written back too early, after %0d cycles",
                     wb_rd, cyc - acc_cyc[wb_rd]);
            errors++;
        end

    a_mul_lost: assert property (@(negedge clk) disable iff (rst) !mul_overdue())
        else begin
            $display("a multiply result was not written back in time");
            errors++;
        end

    // retire a write-back once the checks above have seen it
    always @(negedge clk) begin
        #2;
        if (!rst && wb_valid) begin
            pend[wb_rd] = 1'b0;
            if (pend_div[wb_rd]) begin
                model_div_busy = 1'b0;
            end
            n_checked++;
        end
    end

    task automatic try_issue(input mdu_op_e op, input logic [xw-1:0] a,
                             input logic [xw-1:0] b, output bit taken);
        reg_addr_t rd;
        logic      exp_ready;
        @(negedge clk);
        rd          = free_rd();
        issue_valid = 1'b1;
        issue_op    = op;
        issue_rd    = rd;
        issue_a     = a;
        issue_b     = b;
        #5;
        exp_ready = !(model_div_busy && op[2]);
        assert (issue_ready == exp_ready) else begin
            $display("ERROR issue_ready: expected %h, got %h", exp_ready, issue_ready);
            errors++;
        end
        taken = issue_ready;
        if (taken) begin
            exp_data[rd] = ref_result(op, a, b);
            pend[rd]     = 1'b1;
            pend_div[rd] = op[2];
            acc_cyc[rd]  = cyc + 1;
            if (op[2]) begin
                model_div_busy = 1'b1;
            end
        end
    endtask

    task automatic issue_wait(input mdu_op_e op, input logic [xw-1:0] a,
                              input logic [xw-1:0] b);
        bit taken;
        int tries;
        taken = 1'b0;
        tries = 0;
        while (!taken && tries < 100) begin
            try_issue(op, a, b, taken);
            tries++;
        end
        if (!taken) begin
            $display("operation %s was never accepted", op.name());
            errors++;
        end
    endtask

    task automatic go_idle();
        @(negedge clk);
        issue_valid = 1'b0;
    endtask

    task automatic drain();
        int waited;
        waited = 0;
        while (pend_count() != 0 && waited < 200) begin
            @(negedge clk);
            #3;
            waited++;
        end
        if (pend_count() != 0) begin
            $display("%0d results still outstanding after 200 cycles", pend_count());
            errors++;
        end
    endtask

    task automatic finish_test(input string name);
        n_tests++;
        $display("test %0d %s: %0d errors", n_tests, name, errors - err_mark);
        err_mark = errors;
    endtask

    initial begin
        logic [xw-1:0] a;
        logic [xw-1:0] b;
        bit            taken;
        issue_valid = 1'b0;
        issue_op    = op_div; // ready must ignore a divide op while valid is low
        issue_rd    = '0;
        issue_a     = '0;
        issue_b     = '0;
        rst         = 1'b1;
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        #5;
        assert (issue_ready == 1'b1) else begin
            $display("ERROR issue_ready: expected %h, got %h", 1'b1, issue_ready);
            errors++;
        end
        assert (wb_valid == 1'b0) else begin
            $display("ERROR wb_valid: expected %h, got %h", 1'b0, wb_valid);
            errors++;
        end
        repeat (10) @(negedge clk);
        finish_test("reset state");

        for (int k = 0; k < 4; k++) begin
            for (int i = 0; i < 36; i++) begin
                issue_wait(mdu_op_e'(k[2:0]), edge_vals[i / 6], edge_vals[i % 6]);
            end
            for (int i = 0; i < n_mul_rand; i++) begin
                issue_wait(mdu_op_e'(k[2:0]), lcg_next(), lcg_next());
            end
        end
        go_idle();
        drain();
        finish_test("multiply");

        for (int k = 4; k < 8; k++) begin
            for (int i = 0; i < n_div_rand; i++) begin
                a = lcg_next();
                b = lcg_next() >> (i * 7); // smaller divisors give longer quotients
                issue_wait(mdu_op_e'(k[2:0]), a, b);
            end
        end
        go_idle();
        drain();
        finish_test("divide and remainder");

        for (int k = 4; k < 8; k++) begin
            issue_wait(mdu_op_e'(k[2:0]), lcg_next(), '0);
            issue_wait(mdu_op_e'(k[2:0]), min_int, '0);
            issue_wait(mdu_op_e'(k[2:0]), min_int, '1);
        end
        go_idle();
        drain();
        finish_test("special cases");

        issue_wait(op_div, lcg_next(), 32'd7);
        try_issue(op_remu, lcg_next(), 32'd3, taken);
        assert (!taken) else begin
            $display("second divide was accepted while one was outstanding");
            errors++;
        end
        for (int i = 0; i < 4; i++) begin
            issue_wait(op_mulhu, lcg_next(), lcg_next());
        end
        issue_wait(op_rem, lcg_next(), 32'd13);
        go_idle();
        drain();
        finish_test("divide back-pressure");

        issue_wait(op_divu, lcg_next(), 32'd5);
        go_idle();
        repeat (28) @(negedge clk);
        for (int i = 0; i < 12; i++) begin
            issue_wait(op_mul, lcg_next(), lcg_next());
        end
        go_idle();
        drain();
        finish_test("write-back arbitration");

        $display("tests %0d, write-backs checked %0d, errors %0d", n_tests, n_checked, errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

    initial begin
        repeat (wd_cycles) @(posedge clk);
        $display("watchdog expired after %0d cycles, run did not finish", wd_cycles);
        $display("Errors found");
        $finish;
    end

endmodule

`default_nettype wire

// ==== verilog/mdu_top.sv ====
`default_nettype none
`timescale 1ns/10ps

module mdu_top #(
    parameter int xlen = rv_pkg::XLEN
) (
    input  wire logic              clk,
    input  wire logic              rst,
    input  wire logic              issue_valid,
    input  wire mdu_pkg::mdu_op_e  issue_op,
    input  wire rv_pkg::reg_addr_t issue_rd,
    input  wire logic [xlen-1:0]   issue_a,
    input  wire logic [xlen-1:0]   issue_b,
    output logic                   issue_ready,
    output logic                   wb_valid,
    output rv_pkg::reg_addr_t      wb_rd,
    output logic [xlen-1:0]        wb_data
);

    import rv_pkg::*;
    import mdu_pkg::*;

    logic            mul_start;
    mdu_op_e         mul_op;
    reg_addr_t       mul_rd;
    logic            mul_done;
    reg_addr_t       mul_done_rd;
    logic [xlen-1:0] mul_result;

    logic            div_start;
    logic [1:0]      div_ctrl;
    reg_addr_t       div_rd;
    logic            division_done;
    logic [xlen-1:0] div_result;
    logic            div_taken;

    mdu_dispatch #(.xlen(xlen)) u_dispatch (
        .clk         (clk),
        .rst         (rst),
        .issue_valid (issue_valid),
        .issue_op    (issue_op),
        .issue_rd    (issue_rd),
        .div_taken   (div_taken),
        .issue_ready (issue_ready),
        .mul_start   (mul_start),
        .mul_op      (mul_op),
        .mul_rd      (mul_rd),
        .div_start   (div_start),
        .div_ctrl    (div_ctrl),
        .div_rd      (div_rd)
    );

    mul #(.xlen(xlen)) u_mul (
        .clk     (clk),
        .rst     (rst),
        .start   (mul_start),
        .op      (mul_op),
        .rd      (mul_rd),
        .a       (issue_a),
        .b       (issue_b),
        .done    (mul_done),
        .done_rd (mul_done_rd),
        .product (mul_result)
    );

    div #(.d_width(xlen)) u_div (
        .clk           (clk),
        .rst           (rst),
        .start         (div_start),
        .div_ctrl      (div_ctrl),
        .numerator     (issue_a),
        .denominator   (issue_b),
        .result        (div_result),
        .division_done (division_done)
    );

    wb_arbiter #(.xlen(xlen)) u_arbiter (
        .clk           (clk),
        .rst           (rst),
        .mul_done      (mul_done),
        .mul_rd        (mul_done_rd),
        .mul_result    (mul_result),
        .division_done (division_done),
        .div_rd        (div_rd),
        .div_result    (div_result),
        .wb_valid      (wb_valid),
        .wb_rd         (wb_rd),
        .wb_data       (wb_data),
        .div_taken     (div_taken)
    );

endmodule

`default_nettype wire

// ==== verilog/wb_arbiter.sv ====
`default_nettype none
`timescale 1ns/10ps

module wb_arbiter #(
    parameter int xlen = 32
) (
    input  wire logic              clk,
    input  wire logic              rst,
    input  wire logic              mul_done,
    input  wire rv_pkg::reg_addr_t mul_rd,
    input  wire logic [xlen-1:0]   mul_result,
    input  wire logic              division_done,
    input  wire rv_pkg::reg_addr_t div_rd,
    input  wire logic [xlen-1:0]   div_result,
    output logic                   wb_valid,
    output rv_pkg::reg_addr_t      wb_rd,
    output logic [xlen-1:0]        wb_data,
    output logic                   div_taken
);

    import rv_pkg::*;

    logic            div_done_q;
    logic            div_rise;
    logic            pending;
    reg_addr_t       pend_rd;
    logic [xlen-1:0] pend_data;

    assign div_rise  = division_done & ~div_done_q;
    assign div_taken = pending & ~mul_done; // multiply always wins the port

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            div_done_q <= 1'b1; // divider idles with done high
            pending    <= 1'b0;
            wb_valid   <= 1'b0;
        end else begin
            div_done_q <= division_done;
            if (div_rise) begin
                pending <= 1'b1;
            end else if (div_taken) begin
                pending <= 1'b0;
            end
            wb_valid <= mul_done | pending;
        end
    end

    always_ff @(posedge clk) begin
        if (div_rise) begin
            pend_rd   <= div_rd;
            pend_data <= div_result;
        end
        if (mul_done) begin
            wb_rd   <= mul_rd;
            wb_data <= mul_result;
        end else if (pending) begin
            wb_rd   <= pend_rd;
            wb_data <= pend_data;
        end
    end

    a_no_overrun: assert property (
        @(posedge clk) disable iff (rst) div_rise |-> !pending
    );

endmodule

`default_nettype wire

// ==== verilog/mdu_dispatch.sv ====
`default_nettype none
`timescale 1ns/10ps

module mdu_dispatch #(
    parameter int xlen = 32
) (
    input  wire logic              clk,
    input  wire logic              rst,
    input  wire logic              issue_valid,
    input  wire mdu_pkg::mdu_op_e  issue_op,
    input  wire rv_pkg::reg_addr_t issue_rd,
    input  wire logic              div_taken,
    output logic                   issue_ready,
    output logic                   mul_start,
    output mdu_pkg::mdu_op_e       mul_op,
    output rv_pkg::reg_addr_t      mul_rd,
    output logic                   div_start,
    output logic [1:0]             div_ctrl,
    output rv_pkg::reg_addr_t      div_rd
);

    import mdu_pkg::*;

    logic is_div;
    logic accept;
    logic div_busy; // one divide in flight until written back

    // the divider counter is sized for these two widths only
    if (!(xlen == 32 || xlen == 64)) begin : g_bad_xlen
        $error("mdu_dispatch: xlen must be 32 or 64");
    end

    assign is_div      = op_is_div(issue_op);
    assign issue_ready = ~(div_busy & is_div);
    assign accept      = issue_valid & issue_ready;

    assign mul_start = accept & ~is_div;
    assign mul_op    = issue_op;
    assign mul_rd    = issue_rd;
    assign div_start = accept & is_div;
    assign div_ctrl  = op_div_ctrl(issue_op);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            div_busy <= 1'b0;
        end else if (div_start) begin
            div_busy <= 1'b1;
        end else if (div_taken) begin
            div_busy <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (div_start) begin
            div_rd <= issue_rd; // tag for the arbiter
        end
    end

    // a divide result is only taken while one is outstanding
    a_taken_busy: assert property (
        @(posedge clk) disable iff (rst) div_taken |-> div_busy
    );

endmodule

`default_nettype wire

// ==== mul/mul.sv ====
`default_nettype none
`timescale 1ns/10ps

module mul #(
    parameter int xlen = 32
) (
    input  wire logic              clk,
    input  wire logic              rst,
    input  wire logic              start,
    input  wire mdu_pkg::mdu_op_e  op,
    input  wire rv_pkg::reg_addr_t rd,
    input  wire logic [xlen-1:0]   a,
    input  wire logic [xlen-1:0]   b,
    output logic                   done,
    output rv_pkg::reg_addr_t      done_rd,
    output logic [xlen-1:0]        product
);

    import rv_pkg::*;
    import mdu_pkg::*;

    logic                     a_signed;
    logic                     b_signed;
    logic signed [xlen:0]     a_ext;
    logic signed [xlen:0]     b_ext;
    logic signed [2*xlen+1:0] full_prod;

    // stage 1
    logic                s1_valid;
    mdu_op_e             s1_op;
    reg_addr_t           s1_rd;
    logic [2*xlen-1:0]   s1_prod;

    assign a_signed = (op == op_mulh) || (op == op_mulhsu);
    assign b_signed = (op == op_mulh);

    // one extra bit lets a single signed multiply cover all variants
    assign a_ext     = $signed({a_signed & a[xlen-1], a});
    assign b_ext     = $signed({b_signed & b[xlen-1], b});
    assign full_prod = a_ext * b_ext;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            s1_valid <= 1'b0;
            done     <= 1'b0;
        end else begin
            s1_valid <= start;
            done     <= s1_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            s1_op   <= op;
            s1_rd   <= rd;
            s1_prod <= full_prod[2*xlen-1:0];
        end
        if (s1_valid) begin
            done_rd <= s1_rd;
            if (s1_op == op_mul) begin
                product <= s1_prod[xlen-1:0];      // low half
            end else begin
                product <= s1_prod[2*xlen-1:xlen]; // MULH*
            end
        end
    end

endmodule

`default_nettype wire

// ==== div/div.sv ====
`default_nettype none
`timescale 1ns/10ps

module div #(
    parameter int d_width = 32
) (
    input  wire logic               clk,
    input  wire logic               rst,
    input  wire logic               start,
    input  wire logic [1:0]         div_ctrl,
    input  wire logic [d_width-1:0] numerator,
    input  wire logic [d_width-1:0] denominator,
    output logic      [d_width-1:0] result,
    output logic                    division_done
);

    import mdu_pkg::*;

    localparam logic [5:0] last_step = 6'(d_width - 1);

    div_state_e state;
    div_state_e next_state;
    logic [5:0] counter;

    // operands captured on the accept edge
    logic [1:0]         ctrl_q;
    logic [d_width-1:0] num_q;
    logic [d_width-1:0] den_q;

    logic [d_width:0]   rem;
    logic [d_width-1:0] quo;
    logic [d_width-1:0] div_shift; // dividend bits still to consume
    logic [d_width:0]   den;
    logic [d_width:0]   rem_shift;

    logic               sign_q;
    logic               sign_r;
    logic               is_signed;
    logic               num_neg;
    logic               den_neg;

    assign is_signed = ~ctrl_q[0];                    // DIV and REM
    assign num_neg   = is_signed & num_q[d_width-1];
    assign den_neg   = is_signed & den_q[d_width-1];
    assign rem_shift = {rem[d_width-1:0], div_shift[d_width-1]};

    always_comb begin
        next_state = state;
        case (state)
            idle:    if (start) next_state = init;
            init:    next_state = divide;
            divide:  if (counter == last_step) next_state = done;
            done:    next_state = idle;
            default: next_state = idle;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state         <= idle;
            counter       <= '0;
            division_done <= 1'b1;
        end else begin
            state <= next_state;
            if (state == idle && start) begin
                division_done <= 1'b0;
            end else if (state == done) begin
                division_done <= 1'b1;
            end
            if (state == divide && next_state == divide) begin
                counter <= counter + 6'd1;
            end else begin
                counter <= '0;
            end
        end
    end

    always_ff @(posedge clk) begin
        case (state)
            idle: begin
                if (start) begin
                    num_q  <= numerator;
                    den_q  <= denominator;
                    ctrl_q <= div_ctrl;
                end
            end
            init: begin
                rem       <= '0;
                quo       <= '0;
                sign_q    <= (num_neg ^ den_neg) & (|den_q); // x/0 stays all ones
                sign_r    <= num_neg;
                div_shift <= num_neg ? -num_q : num_q;
                den       <= {1'b0, den_neg ? -den_q : den_q};
            end
            divide: begin
                div_shift <= div_shift << 1;
                if (rem_shift >= den) begin
                    rem <= rem_shift - den;
                    quo <= {quo[d_width-2:0], 1'b1};
                end else begin
                    rem <= rem_shift;
                    quo <= {quo[d_width-2:0], 1'b0};
                end
            end
            done: begin
                case (ctrl_q)
                    2'b00:   result <= sign_q ? -quo : quo;
                    2'b01:   result <= quo;
                    2'b10:   result <= sign_r ? -rem[d_width-1:0] : rem[d_width-1:0];
                    default: result <= rem[d_width-1:0];
                endcase
            end
            default: ;
        endcase
    end

    a_counter_range: assert property (
        @(posedge clk) disable iff (rst) counter <= last_step
    );

endmodule

`default_nettype wire

// ==== common/mdu_pkg.sv ====
`default_nettype none

package mdu_pkg;

    // M extension ops, encoded as funct3
    typedef enum logic [2:0] {
        op_mul    = 3'b000,
        op_mulh   = 3'b001,
        op_mulhsu = 3'b010,
        op_mulhu  = 3'b011,
        op_div    = 3'b100,
        op_divu   = 3'b101,
        op_rem    = 3'b110,
        op_remu   = 3'b111
    } mdu_op_e;

    // iterative divider sequencing
    typedef enum logic [1:0] {
        idle,
        init,
        divide,
        done
    } div_state_e;

    // funct3[2] splits multiply from divide
    function automatic logic op_is_div(mdu_op_e op);
        return op[2];
    endfunction

    // low two bits drive the divider: DIV, DIVU, REM, REMU
    function automatic logic [1:0] op_div_ctrl(mdu_op_e op);
        return op[1:0];
    endfunction

endpackage

`default_nettype wire

// ==== common/rv_pkg.sv ====
`default_nettype none

package rv_pkg;

    // integer register width of the core
    localparam int XLEN = 32;

    // architectural register file
    localparam int REG_COUNT  = 32;
    localparam int REG_ADDR_W = $clog2(REG_COUNT);

    typedef logic [REG_ADDR_W-1:0] reg_addr_t; // rd / rs1 / rs2

    // x0 reads as zero
    localparam reg_addr_t REG_ZERO = '0;

endpackage

`default_nettype wire
